// File: common/cpu16_consts.svh
// Widths are tied to the 16-bit instruction layout and cannot be changed on their own
`ifndef CPU16_CONSTS_SVH
`define CPU16_CONSTS_SVH

// Data path and instruction word width
`define CPU16_DATA_BITS 16

// Register select field width
`define CPU16_REG_BITS 4

// Register file size, R0 included
`define CPU16_NUM_REGS 16

`endif

// File: common/cpu16_isa_pkg.sv
// Opcodes outside the listed set decode as no-ops that write no register and no flag
package cpu16_isa_pkg;

`include "cpu16_consts.svh"

	typedef logic [`CPU16_DATA_BITS-1:0] word_t;
	typedef logic [`CPU16_REG_BITS-1:0] reg_sel_t;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,	// rd = ra + rb
		OP_SUB  = 4'h1,	// rd = ra - rb
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5,	// rd = rd + imm8
		OP_LDI  = 4'h6,	// rd = imm8
		OP_CMP  = 4'h7,	// Flag only
		OP_MOVZ = 4'h8,	// rd = ra when the zero flag is set
		OP_OUT  = 4'h9	// Emit ra on the output stream
	} opcode_e;

	// Instruction word as it arrives on the input stream
	typedef struct packed {
		opcode_e  opcode;	// Bits 15..12
		reg_sel_t rd;	// Bits 11..8
		reg_sel_t ra;	// Bits 7..4 and high nibble of imm8
		reg_sel_t rb;	// Bits 3..0 and low nibble of imm8
	} instr_t;

	// Everything execute needs from decode
	typedef struct packed {
		opcode_e  op;
		reg_sel_t rd;
		word_t    a_val;
		word_t    b_val;
		word_t    imm;	// Sign-extended imm8
		logic     wr_en;	// Writes rd unless MOVZ fails its condition
	} decoded_op_t;

endpackage

// File: common/cpu16_pipe_pkg.sv
// Each slot carries its hazard tag so that decode can see what is still in flight
package cpu16_pipe_pkg;

	// R0 as destination means the instruction writes no register
	typedef struct packed {
		cpu16_isa_pkg::reg_sel_t dest;
		logic                    modifies_flags;
	} hazard_tag_t;

	// Payload between decode and execute
	typedef struct packed {
		cpu16_isa_pkg::decoded_op_t op;
		hazard_tag_t                tag;
	} exec_slot_t;

	// Payload between execute and retirement
	typedef struct packed {
		cpu16_isa_pkg::reg_sel_t wr_sel;
		cpu16_isa_pkg::word_t    wr_data;	// Also the value emitted by OUT
		logic                    wr_en;
		logic                    flag_val;	// New zero flag
		logic                    flag_wr;
		logic                    is_out;
		hazard_tag_t             tag;
	} result_slot_t;

endpackage

// File: logic/cpu16_stage_reg.sv
// Holds one item and takes a new one in the same cycle that the held item leaves
`timescale 1ns/100ps

module cpu16_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     up_valid,
	output logic     up_ready,
	input  payload_t up_data,
	output logic     dn_valid,
	input  logic     dn_ready,
	output payload_t dn_data
);

	logic     full;
	payload_t data_q;

	assign up_ready = !full || dn_ready;	// Empty or draining this cycle
	assign dn_valid = full;
	assign dn_data  = data_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			full <= 1'b0;
		else if (up_ready)
			full <= up_valid;
	end

	// Payload only moves on an accepted transfer
	always_ff @(posedge clk) begin
		if (up_valid && up_ready)
			data_q <= up_data;
	end

endmodule

// File: logic/cpu16_regfile.sv
// R0 reads zero, and a write is not bypassed to the read ports in the same cycle
`timescale 1ns/100ps
`include "cpu16_consts.svh"

module cpu16_regfile (
	input  logic                    clk,
	input  logic                    arst_n,
	input  cpu16_isa_pkg::reg_sel_t ra_sel,
	input  cpu16_isa_pkg::reg_sel_t rb_sel,
	output cpu16_isa_pkg::word_t    ra_data,
	output cpu16_isa_pkg::word_t    rb_data,
	input  logic                    wr_en,
	input  cpu16_isa_pkg::reg_sel_t wr_sel,
	input  cpu16_isa_pkg::word_t    wr_data
);
	import cpu16_isa_pkg::*;

	word_t regs [`CPU16_NUM_REGS];

	assign ra_data = (ra_sel == '0) ? '0 : regs[ra_sel];
	assign rb_data = (rb_sel == '0) ? '0 : regs[rb_sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU16_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_sel != '0) begin	// Writes to R0 are dropped
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// File: pipeline/cpu16_decode.sv
// Operands are read in the issue cycle, so the instruction waits here until no producer is in flight
`timescale 1ns/100ps
`include "cpu16_consts.svh"

module cpu16_decode (
	input  logic                        in_valid,
	output logic                        in_ready,
	input  cpu16_isa_pkg::instr_t       in_instr,
	output cpu16_isa_pkg::reg_sel_t     ra_sel,
	output cpu16_isa_pkg::reg_sel_t     rb_sel,
	input  cpu16_isa_pkg::word_t        ra_data,
	input  cpu16_isa_pkg::word_t        rb_data,
	input  logic                        stall,
	output logic                        slot_valid,
	input  logic                        slot_ready,
	output cpu16_pipe_pkg::exec_slot_t  slot,
	output cpu16_pipe_pkg::hazard_tag_t tag,
	output logic                        uses_flags
);
	import cpu16_isa_pkg::*;

	decoded_op_t op_d;
	logic [7:0]  imm8;
	logic        writes_rd;
	logic        mod_flags;

	assign imm8 = {in_instr.ra, in_instr.rb};

	// Selects stay at R0 without a valid word so an idle stream never stalls
	always_comb begin
		ra_sel     = '0;
		rb_sel     = '0;
		uses_flags = 1'b0;
		writes_rd  = 1'b0;
		mod_flags  = 1'b0;
		if (in_valid) begin
			case (in_instr.opcode)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
					ra_sel    = in_instr.ra;
					rb_sel    = in_instr.rb;
					writes_rd = 1'b1;
					mod_flags = 1'b1;
				end
				OP_ADDI: begin
					ra_sel    = in_instr.rd;	// rd is source and destination
					writes_rd = 1'b1;
					mod_flags = 1'b1;
				end
				OP_LDI:  writes_rd = 1'b1;
				OP_CMP: begin
					ra_sel    = in_instr.ra;
					rb_sel    = in_instr.rb;
					mod_flags = 1'b1;
				end
				OP_MOVZ: begin
					ra_sel     = in_instr.ra;
					writes_rd  = 1'b1;
					uses_flags = 1'b1;
				end
				OP_OUT:  ra_sel = in_instr.ra;
				default: ;
			endcase
		end
	end

	assign op_d.op    = in_instr.opcode;
	assign op_d.rd    = in_instr.rd;
	assign op_d.a_val = ra_data;
	assign op_d.b_val = rb_data;
	assign op_d.imm   = {{(`CPU16_DATA_BITS - 8){imm8[7]}}, imm8};
	assign op_d.wr_en = writes_rd;

	assign tag  = '{dest: writes_rd ? in_instr.rd : '0, modifies_flags: mod_flags};
	assign slot = '{op: op_d, tag: tag};

	assign slot_valid = in_valid && !stall;
	assign in_ready   = slot_ready && !stall;

endmodule

// File: pipeline/cpu16_hazard.sv
// No forwarding exists, so any read of a register or flag still owed by a slot stalls
`timescale 1ns/100ps

module cpu16_hazard (
	input  cpu16_isa_pkg::reg_sel_t     ra_sel,
	input  cpu16_isa_pkg::reg_sel_t     rb_sel,
	input  logic                        uses_flags,
	input  cpu16_pipe_pkg::hazard_tag_t tag_ex,
	input  cpu16_pipe_pkg::hazard_tag_t tag_rs,
	input  logic                        ex_valid,
	input  logic                        rs_valid,
	output logic                        stall
);
	import cpu16_isa_pkg::*;
	import cpu16_pipe_pkg::*;

	logic raw_a;
	logic raw_b;
	logic flag_dep;

	// R0 is never a real dependence
	function automatic logic reg_hit(
		input reg_sel_t    sel,
		input hazard_tag_t tag,
		input logic        valid
	);
		return valid && sel != '0 && sel == tag.dest;
	endfunction

	always_comb begin
		raw_a = reg_hit(ra_sel, tag_ex, ex_valid) || reg_hit(ra_sel, tag_rs, rs_valid);
		raw_b = reg_hit(rb_sel, tag_ex, ex_valid) || reg_hit(rb_sel, tag_rs, rs_valid);
	end

	// MOVZ must see the flag of every older flag writer
	assign flag_dep = uses_flags &&
		((ex_valid && tag_ex.modifies_flags) || (rs_valid && tag_rs.modifies_flags));

	assign stall = raw_a || raw_b || flag_dep;

endmodule

// File: pipeline/cpu16_execute.sv
// MOVZ samples the retired zero flag here, which decode keeps current by stalling on flag writers
`timescale 1ns/100ps

module cpu16_execute (
	input  logic                         ex_valid,
	output logic                         ex_ready,
	input  cpu16_pipe_pkg::exec_slot_t   ex_slot,
	input  logic                         zero_flag,
	output logic                         rs_valid,
	input  logic                         rs_ready,
	output cpu16_pipe_pkg::result_slot_t rs_slot
);
	import cpu16_isa_pkg::*;

	decoded_op_t dop;
	word_t       alu;
	logic        move_ok;

	assign dop = ex_slot.op;

	always_comb begin
		case (dop.op)
			OP_ADD:  alu = dop.a_val + dop.b_val;
			OP_SUB:  alu = dop.a_val - dop.b_val;
			OP_AND:  alu = dop.a_val & dop.b_val;
			OP_OR:   alu = dop.a_val | dop.b_val;
			OP_XOR:  alu = dop.a_val ^ dop.b_val;
			OP_ADDI: alu = dop.a_val + dop.imm;
			OP_LDI:  alu = dop.imm;
			OP_CMP:  alu = dop.a_val - dop.b_val;	// Only the zero test is kept
			OP_MOVZ: alu = dop.a_val;
			OP_OUT:  alu = dop.a_val;
			default: alu = '0;
		endcase
	end

	assign move_ok = (dop.op != OP_MOVZ) || zero_flag;

	assign rs_slot = '{
		wr_sel:   dop.rd,
		wr_data:  alu,
		wr_en:    dop.wr_en && move_ok,
		flag_val: (alu == '0),
		flag_wr:  ex_slot.tag.modifies_flags,
		is_out:   (dop.op == OP_OUT),
		tag:      ex_slot.tag
	};

	// No state of its own
	assign rs_valid = ex_valid;
	assign ex_ready = rs_ready;

endmodule

// File: pipeline/cpu16_result.sv
// Only OUT can hold the last slot, everything else retires in the cycle it arrives
`timescale 1ns/100ps

module cpu16_result (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         rs_valid,
	output logic                         rs_ready,
	input  cpu16_pipe_pkg::result_slot_t rs_slot,
	output logic                         wr_en,
	output cpu16_isa_pkg::reg_sel_t      wr_sel,
	output cpu16_isa_pkg::word_t         wr_data,
	output logic                         zero_flag,
	output logic                         out_valid,
	input  logic                         out_ready,
	output cpu16_isa_pkg::word_t         out_data
);

	logic retire;
	logic flag_q;

	assign rs_ready = !rs_slot.is_out || out_ready;
	assign retire   = rs_valid && rs_ready;

	// Register write lands on the retiring edge
	assign wr_en   = retire && rs_slot.wr_en;
	assign wr_sel  = rs_slot.wr_sel;
	assign wr_data = rs_slot.wr_data;

	assign out_valid = rs_valid && rs_slot.is_out;
	assign out_data  = rs_slot.wr_data;	// Held by the slot until the handshake

	assign zero_flag = flag_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			flag_q <= 1'b0;
		else if (retire && rs_slot.flag_wr)
			flag_q <= rs_slot.flag_val;
	end

endmodule

// File: logic/cpu16_core.sv
// Up to two instructions in flight behind decode, and OUT back-pressure fills both slots before in_ready drops
`timescale 1ns/100ps
`include "cpu16_consts.svh"

module cpu16_core (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic [`CPU16_DATA_BITS-1:0] in_instr,
	output logic                        out_valid,
	input  logic                        out_ready,
	output logic [`CPU16_DATA_BITS-1:0] out_data
);
	import cpu16_isa_pkg::*;
	import cpu16_pipe_pkg::*;

	reg_sel_t     ra_sel;
	reg_sel_t     rb_sel;
	word_t        ra_data;
	word_t        rb_data;
	logic         stall;
	logic         uses_flags;
	logic         dec_valid;
	logic         dec_ready;
	exec_slot_t   dec_slot;
	logic         ex_valid;
	logic         ex_ready;
	exec_slot_t   ex_data;
	logic         xo_valid;
	logic         xo_ready;
	result_slot_t xo_slot;
	logic         rs_valid;
	logic         rs_ready;
	result_slot_t rs_data;
	logic         wr_en;
	reg_sel_t     wr_sel;
	word_t        wr_data;
	logic         zero_flag;

	cpu16_regfile regfile_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_sel  (ra_sel),
		.rb_sel  (rb_sel),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data)
	);

	cpu16_decode decode_i (
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_instr   (in_instr),
		.ra_sel     (ra_sel),
		.rb_sel     (rb_sel),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.stall      (stall),
		.slot_valid (dec_valid),
		.slot_ready (dec_ready),
		.slot       (dec_slot),
		.tag        (),	// Same tag already rides inside dec_slot
		.uses_flags (uses_flags)
	);

	cpu16_hazard hazard_i (
		.ra_sel     (ra_sel),
		.rb_sel     (rb_sel),
		.uses_flags (uses_flags),
		.tag_ex     (ex_data.tag),
		.tag_rs     (rs_data.tag),
		.ex_valid   (ex_valid),
		.rs_valid   (rs_valid),
		.stall      (stall)
	);

	cpu16_stage_reg #(.payload_t(exec_slot_t)) ex_slot (
		.clk      (clk),
		.arst_n   (arst_n),
		.up_valid (dec_valid),
		.up_ready (dec_ready),
		.up_data  (dec_slot),
		.dn_valid (ex_valid),
		.dn_ready (ex_ready),
		.dn_data  (ex_data)
	);

	cpu16_execute execute_i (
		.ex_valid  (ex_valid),
		.ex_ready  (ex_ready),
		.ex_slot   (ex_data),
		.zero_flag (zero_flag),
		.rs_valid  (xo_valid),
		.rs_ready  (xo_ready),
		.rs_slot   (xo_slot)
	);

	cpu16_stage_reg #(.payload_t(result_slot_t)) rs_slot (
		.clk      (clk),
		.arst_n   (arst_n),
		.up_valid (xo_valid),
		.up_ready (xo_ready),
		.up_data  (xo_slot),
		.dn_valid (rs_valid),
		.dn_ready (rs_ready),
		.dn_data  (rs_data)
	);

	cpu16_result result_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rs_valid  (rs_valid),
		.rs_ready  (rs_ready),
		.rs_slot   (rs_data),
		.wr_en     (wr_en),
		.wr_sel    (wr_sel),
		.wr_data   (wr_data),
		.zero_flag (zero_flag),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

// File: verification/cpu16_core_tb.sv
// Inputs change 2 ns after the rising edge and every check samples on the falling edge
`timescale 1ns/100ps
`include "cpu16_consts.svh"

module cpu16_core_tb;
	import cpu16_isa_pkg::*;

	localparam int T2_LEN = 16;
	localparam int T3_LEN = 14;
	localparam int T4_LEN = 14;
	localparam int T5_LEN = 48;
	localparam int CYCLE_LIMIT = 8 * (T2_LEN + T3_LEN + T4_LEN + T5_LEN) + 200;
	localparam int DRAIN_LIMIT = 64;	// At most two slots still hold values when a stream stops

	logic                        clk;
	logic                        arst_n;
	logic                        in_valid;
	logic                        in_ready;
	logic [`CPU16_DATA_BITS-1:0] in_instr;
	logic                        out_valid;
	logic                        out_ready;
	logic [`CPU16_DATA_BITS-1:0] out_data;

	int          seed = 39720;
	logic [31:0] r;
	logic [3:0]  pick;
	logic        rand_ready;
	logic [15:0] prog [$];	// Instructions of the current test
	logic [15:0] exp_q [$];	// OUT values in program order
	logic [15:0] model_regs [`CPU16_NUM_REGS];
	logic        model_flag;
	logic [15:0] exp_val;
	logic [15:0] held_data;
	logic        hold_prev;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          err_mark = 0;
	int          stall_cycles = 0;
	int          stall_mark = 0;
	int          outs_seen = 0;
	int          outs_expected = 0;
	int          cycles = 0;

	cpu16_core dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	// Random sink stalls only while enabled
	always begin
		@(posedge clk);
		#2;
		out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
	end

	function automatic logic [15:0] rrr_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
		return {op, rd, ra, rb};
	endfunction

	function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	// Architectural model that steps once per accepted instruction
	task automatic model_step(input logic [15:0] w);
		logic [3:0]  rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm;
		logic [15:0] res;
		logic        wr;
		logic        fl;
		rd = w[11:8];
		a = model_regs[w[7:4]];
		b = model_regs[w[3:0]];
		imm = {{8{w[7]}}, w[7:0]};
		res = '0;
		wr = 1'b1;
		fl = 1'b1;
		case (opcode_e'(w[15:12]))
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = model_regs[rd] + imm;
			OP_LDI: begin
				res = imm;
				fl = 1'b0;
			end
			OP_CMP: begin
				res = a - b;
				wr = 1'b0;
			end
			OP_MOVZ: begin
				res = a;
				wr = model_flag;	// Moves only on a set flag
				fl = 1'b0;
			end
			default: begin	// OUT
				exp_q.push_back(a);
				outs_expected++;
				wr = 1'b0;
				fl = 1'b0;
			end
		endcase
		if (wr && rd != 4'd0)
			model_regs[rd] = res;
		if (fl)
			model_flag = (res == 16'h0);
	endtask

	always @(negedge clk) begin
		if (arst_n) begin
			if (in_valid && !in_ready)
				stall_cycles++;
			if (in_valid && in_ready)
				model_step(in_instr);	// Transfer happens at the coming edge
			if (hold_prev) begin
				checks++;
				assert (out_valid) else begin
					$display("out_valid dropped before its handshake at %0t", $time);
					errors++;
				end
				assert (out_data == held_data) else begin
					$display("mismatch at %0t: out_data moved from %h to %h while stalled",
						$time, held_data, out_data);
					errors++;
				end
			end
			if (out_valid && out_ready) begin
				checks++;
				outs_seen++;
				assert (exp_q.size() != 0) else begin
					$display("output %h at %0t arrived with no value expected", out_data, $time);
					errors++;
				end
				if (exp_q.size() != 0) begin
					exp_val = exp_q.pop_front();
					assert (out_data == exp_val) else begin
						$display("mismatch at %0t: OUT gave %h, expected %h",
							$time, out_data, exp_val);
						errors++;
					end
				end
			end
			hold_prev = out_valid && !out_ready;
			held_data = out_data;
		end
	end

	task automatic run_program();
		logic taken;
		@(posedge clk);
		#2;
		foreach (prog[i]) begin
			in_valid = 1'b1;
			in_instr = prog[i];
			do begin
				@(negedge clk);
				taken = in_ready;
				@(posedge clk);
				#2;
			end while (!taken);
		end
		in_valid = 1'b0;
		prog.delete();
	endtask

	// Gives up after a bounded wait so that a lost value shows up as pending
	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic load_random(input logic [3:0] rd);
		r = $random(seed);
		prog.push_back(imm_word(OP_LDI, rd, r[7:0]));
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0s: ok", name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b1;
		rand_ready = 1'b0;
		hold_prev = 1'b0;
		held_data = '0;
		model_flag = 1'b0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;

		@(negedge clk);
		checks++;
		assert (!out_valid && in_ready) else begin
			$display("out_valid high or in_ready low after reset at %0t", $time);
			errors++;
		end
		finish_test("reset");

		for (int i = 1; i <= 4; i++)
			load_random(4'(i));
		prog.push_back(rrr_word(OP_ADD, 4'd5, 4'd1, 4'd2));
		prog.push_back(rrr_word(OP_SUB, 4'd6, 4'd3, 4'd4));
		prog.push_back(rrr_word(OP_AND, 4'd7, 4'd1, 4'd3));
		prog.push_back(rrr_word(OP_OR, 4'd8, 4'd2, 4'd4));
		prog.push_back(rrr_word(OP_XOR, 4'd9, 4'd1, 4'd4));
		r = $random(seed);
		prog.push_back(imm_word(OP_ADDI, 4'd1, r[7:0]));
		for (int i = 5; i <= 9; i++)
			prog.push_back(rrr_word(OP_OUT, 4'd0, 4'(i), 4'd0));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd1, 4'd0));
		run_program();
		drain_outputs();
		finish_test("independent ops");

		stall_mark = stall_cycles;
		load_random(4'd1);
		prog.push_back(rrr_word(OP_ADD, 4'd2, 4'd1, 4'd1));	// Distance 1
		prog.push_back(rrr_word(OP_SUB, 4'd3, 4'd2, 4'd1));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd3, 4'd0));
		load_random(4'd4);
		load_random(4'd5);
		prog.push_back(rrr_word(OP_XOR, 4'd6, 4'd4, 4'd0));	// Distance 2 on r4
		prog.push_back(rrr_word(OP_OR, 4'd7, 4'd5, 4'd6));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd7, 4'd0));
		prog.push_back(imm_word(OP_LDI, 4'd0, 8'h5a));	// R0 must stay zero
		prog.push_back(imm_word(OP_ADDI, 4'd0, 8'h03));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd0, 4'd0));
		prog.push_back(rrr_word(OP_ADD, 4'd8, 4'd0, 4'd1));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd8, 4'd0));
		run_program();
		drain_outputs();
		checks++;
		assert (stall_cycles > stall_mark) else begin
			$display("in_ready never went low during the dependence sequence");
			errors++;
		end
		finish_test("dependences");

		prog.push_back(imm_word(OP_LDI, 4'd1, 8'h07));
		prog.push_back(imm_word(OP_LDI, 4'd2, 8'h07));
		prog.push_back(imm_word(OP_LDI, 4'd3, 8'h22));
		prog.push_back(imm_word(OP_LDI, 4'd4, 8'h09));
		prog.push_back(imm_word(OP_LDI, 4'd6, 8'h11));
		prog.push_back(imm_word(OP_LDI, 4'd7, 8'h33));
		prog.push_back(rrr_word(OP_CMP, 4'd7, 4'd1, 4'd2));	// Equal operands with rd set
		prog.push_back(rrr_word(OP_MOVZ, 4'd5, 4'd3, 4'd0));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd5, 4'd0));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd7, 4'd0));
		prog.push_back(rrr_word(OP_CMP, 4'd7, 4'd1, 4'd4));	// Not equal
		prog.push_back(rrr_word(OP_MOVZ, 4'd6, 4'd3, 4'd0));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd6, 4'd0));
		prog.push_back(rrr_word(OP_OUT, 4'd0, 4'd7, 4'd0));
		run_program();
		drain_outputs();
		finish_test("cmp and movz");

		// Opcodes above MOVZ fold into OUT so the sink sees plenty of traffic
		for (int i = 0; i < T5_LEN; i++) begin
			r = $random(seed);
			pick = r[19:16];
			if (pick > 4'd9)
				pick = OP_OUT;
			prog.push_back({pick, r[11:0]});
		end
		rand_ready = 1'b1;
		run_program();
		drain_outputs();
		rand_ready = 1'b0;
		finish_test("random back-pressure");

		@(negedge clk);
		checks++;
		assert (exp_q.size() == 0 && !out_valid) else begin
			$display("%0d values still pending after the stream ended", exp_q.size());
			errors++;
		end
		assert (outs_seen == outs_expected) else begin
			$display("%0d outputs seen but %0d expected", outs_seen, outs_expected);
			errors++;
		end
		finish_test("end of stream");

		$display("tests %0d run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: cpu16_core.f
+incdir+common
common/cpu16_isa_pkg.sv
common/cpu16_pipe_pkg.sv
logic/cpu16_stage_reg.sv
logic/cpu16_regfile.sv
pipeline/cpu16_decode.sv
pipeline/cpu16_hazard.sv
pipeline/cpu16_execute.sv
pipeline/cpu16_result.sv
logic/cpu16_core.sv
verification/cpu16_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cpu16_core testbench with Verilator and runs it once
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f cpu16_core.f --top-module cpu16_core_tb \
	--Mdir obj_dir -o cpu16_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/cpu16_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
exit 0
